// ==== bench/signalGen_input.txt ====
// Columns in hex: shape frequency amplitude cycles expected_sample expected_periods
// Shape 0 triangle, 1 square, 2 sawtooth, 3 silent; a shape of ff ends the list
0 3e8 ff 32 f0 1
0 64 ff 12c 24 0
0 1f40 ff f ff 3
0 bb8 ff 19 80 2
1 7d0 ff 14 ff 1
1 7d0 ff c 0 0
2 5dc ff 1e 5c 1
2 1f40 ff 7 80 1
3 3e8 ff 14 0 0
0 3e8 80 32 78 1
2 5dc 80 1e 2e 1
1 7d0 80 14 80 1
0 1f40 0 f 0 3
0 bb8 c8 a 3f 0
ff 0 0 0 0 0

// ==== signalGen.f ====
+incdir+hw
hw/signalGenPkg.sv
hw/signalRegs.sv
hw/phaseAccumulator.sv
hw/waveShaper.sv
hw/amplitudeScaler.sv
hw/signalGenTop.sv
bench/signalGenTb.sv

// ==== runSim.sh ====
#!/usr/bin/env bash
# Builds the tone generator testbench with Verilator and runs it from the project root
# Exit status is 0 only when the simulation output holds the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module signalGenTb -f signalGen.f -o signalGenSim \
	&& ./obj_dir/signalGenSim | tee /dev/stderr | grep -F "Regression passed" > /dev/null \
	&& exit 0 \
	|| exit 1

// ==== bench/signalGenTb.sv ====
// Testbench for the tone generator top level
// Programs each case of the data file over Wishbone, then checks sample and period count
// Run from the project root so that the data file path resolves
`default_nettype none
`include "signalGen_cfg.svh"

module signalGenTb;

	localparam int maxTests = 16;
	localparam int fieldsPerTest = 6;

	logic                    CLK_32KHz;
	logic                    reset_n;
	signalGenPkg::wbRequest  wbIn;
	signalGenPkg::wbResponse wbOut;
	logic [7:0]              outputSample;
	logic                    periodStart;

	logic [31:0] testData [0:maxTests*fieldsPerTest-1]; // Six hex words per case
	int          testCount;
	int          limitCycles; // Watchdog budget, zero until the data is loaded
	int          errorCount;
	int          testsFailed;
	int          seed;
	bit          testFailed;

	signalGenTop dut_i (
		.CLK_32KHz    (CLK_32KHz),
		.reset_n      (reset_n),
		.wbIn         (wbIn),
		.wbOut        (wbOut),
		.outputSample (outputSample),
		.periodStart  (periodStart)
	);

	always #5 CLK_32KHz = ~CLK_32KHz;

	task automatic checkValue(input string name, input logic [15:0] got,
		input logic [15:0] expected);
		assert (got === expected) else begin
			$display("Error: %s is 0x%h, expected 0x%h", name, got, expected);
			errorCount++;
			testFailed = 1'b1;
		end
	endtask

	// One classic transfer, request held until ack, called on a falling edge
	task automatic busAccess(input logic write, input signalGenPkg::regAddr adr,
		input logic [15:0] writeData, output logic [15:0] readData);
		bit gotAck;
		gotAck = 1'b0;
		readData = 16'h0000;
		wbIn.cyc = 1'b1;
		wbIn.stb = 1'b1;
		wbIn.we = write;
		wbIn.adr = adr;
		wbIn.dat = writeData;
		for (int i = 0; i < 8 && !gotAck; i++) begin
			@(negedge CLK_32KHz);
			if (wbOut.ack) begin
				gotAck = 1'b1;
				readData = wbOut.dat; // Valid while ack is high
			end
		end
		wbIn.cyc = 1'b0;
		wbIn.stb = 1'b0;
		wbIn.we = 1'b0;
		assert (gotAck) else begin
			$display("No ack from the register block for address %0d", adr);
			errorCount++;
			testFailed = 1'b1;
		end
	endtask

	task automatic writeReg(input signalGenPkg::regAddr adr, input logic [15:0] data);
		logic [15:0] unused;
		busAccess(1'b1, adr, data, unused);
	endtask

	task automatic readReg(input signalGenPkg::regAddr adr, output logic [15:0] data);
		busAccess(1'b0, adr, 16'h0000, data);
	endtask

	// Random idle time between bus writes
	task automatic idleGap();
		int gap;
		gap = 1 + int'($unsigned($random(seed)) % 4);
		repeat (gap) @(negedge CLK_32KHz);
	endtask

	task automatic checkRegisters();
		logic [15:0] value;
		testFailed = 1'b0;
		readReg(signalGenPkg::REG_FREQUENCY, value);
		checkValue("frequency after reset", value, 16'(`RESET_FREQUENCY));
		readReg(signalGenPkg::REG_AMPLITUDE, value);
		checkValue("amplitude after reset", value, 16'(`RESET_AMPLITUDE));
		readReg(signalGenPkg::REG_CONTROL, value);
		checkValue("control after reset", value, 16'h0000);
		writeReg(signalGenPkg::REG_FREQUENCY, 16'hC5A5);
		readReg(signalGenPkg::REG_FREQUENCY, value);
		checkValue("frequency", value, 16'h05A5); // Only 14 bits stored
		writeReg(signalGenPkg::REG_AMPLITUDE, 16'hAB5C);
		readReg(signalGenPkg::REG_AMPLITUDE, value);
		checkValue("amplitude", value, 16'h005C);
		writeReg(signalGenPkg::REG_CONTROL, 16'h0004); // Sawtooth, stopped
		readReg(signalGenPkg::REG_CONTROL, value);
		checkValue("control", value, 16'h0004);
		// Stopped since reset, so no period has been counted
		readReg(signalGenPkg::REG_PERIODS, value);
		checkValue("periods while stopped", value, 16'h0000);
		writeReg(signalGenPkg::REG_PERIODS, 16'hBEEF);
		readReg(signalGenPkg::REG_PERIODS, value);
		checkValue("periods after write", value, 16'h0000);
		if (testFailed) begin
			testsFailed++;
		end
		$display("Test 0 register readback: %s", testFailed ? "fail" : "ok");
	endtask

	task automatic runTest(input int index);
		int          base;
		int          cycles;
		int          pulses;
		logic [1:0]  shape;
		logic [15:0] value;
		base = index * fieldsPerTest;
		shape = testData[base][1:0];
		cycles = int'(testData[base + 3]);
		testFailed = 1'b0;
		idleGap();
		writeReg(signalGenPkg::REG_FREQUENCY, testData[base + 1][15:0]);
		idleGap();
		writeReg(signalGenPkg::REG_AMPLITUDE, testData[base + 2][15:0]);
		idleGap();
		writeReg(signalGenPkg::REG_CONTROL, {13'h0000, shape, 1'b1});
		// Edges counted from the one after the enable write, wrap pulses seen on the way
		pulses = 0;
		for (int i = 0; i < cycles; i++) begin
			if (periodStart) begin
				pulses++;
			end
			@(negedge CLK_32KHz);
		end
		checkValue("outputSample", {8'h00, outputSample}, {8'h00, testData[base + 4][7:0]});
		checkValue("periodStart pulses", 16'(pulses), testData[base + 5][15:0]);
		readReg(signalGenPkg::REG_PERIODS, value);
		checkValue("periods", value, testData[base + 5][15:0]);
		writeReg(signalGenPkg::REG_CONTROL, {13'h0000, shape, 1'b0});
		// First edge after the write may still carry a sample
		repeat (4) begin
			@(negedge CLK_32KHz);
			checkValue("outputSample after disable", {8'h00, outputSample}, 16'h0000);
		end
		readReg(signalGenPkg::REG_PERIODS, value);
		checkValue("periods after disable", value, 16'h0000);
		if (testFailed) begin
			testsFailed++;
		end
		$display("Test %0d shape %0d frequency %0d amplitude %0d cycles %0d: %s", index + 1,
			shape, testData[base + 1], testData[base + 2], cycles, testFailed ? "fail" : "ok");
	endtask

	initial begin : watchdog
		wait (limitCycles != 0);
		repeat (limitCycles) @(posedge CLK_32KHz);
		$display("Simulation timed out after %0d cycles", limitCycles);
		$display("Regression failed");
		$finish;
	end

	initial begin : mainSequence
		int totalCycles;
		CLK_32KHz = 1'b0;
		reset_n = 1'b0;
		wbIn.cyc = 1'b0;
		wbIn.stb = 1'b0;
		wbIn.we = 1'b0;
		wbIn.adr = signalGenPkg::REG_FREQUENCY;
		wbIn.dat = 16'h0000;
		seed = 47;
		errorCount = 0;
		testsFailed = 0;
		testCount = 0;
		totalCycles = 0;
		$readmemh("bench/signalGen_input.txt", testData);
		while (testCount < maxTests && testData[testCount * fieldsPerTest] != 32'hFF) begin
			totalCycles += int'(testData[testCount * fieldsPerTest + 3]);
			testCount++;
		end
		limitCycles = totalCycles + 40 * (testCount + 2); // Reset and readback add two slots
		repeat (5) @(posedge CLK_32KHz);
		@(negedge CLK_32KHz);
		reset_n = 1'b1;
		checkRegisters();
		for (int i = 0; i < testCount; i++) begin
			runTest(i);
		end
		assert (testCount > 0) else begin
			$display("No test cases were read from the data file");
			errorCount++;
		end
		$display("Tests run %0d, tests failed %0d, errors %0d", testCount + 1, testsFailed,
			errorCount);
		if (errorCount == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== hw/signalGenTop.sv ====
// Top level of the programmable tone generator
// Register block on the Wishbone side steers the phase, shape and scale datapath
`default_nettype none

module signalGenTop (
	input  logic                    CLK_32KHz,
	input  logic                    reset_n,
	input  signalGenPkg::wbRequest  wbIn,
	output signalGenPkg::wbResponse wbOut,
	output logic [7:0]              outputSample,
	output logic                    periodStart // One cycle per wrap
);

	signalGenPkg::genControl control;
	logic [6:0]              stepIndex;
	logic [7:0]              shapedSample;

	signalRegs signalRegs_i (
		.CLK_32KHz (CLK_32KHz),
		.reset_n   (reset_n),
		.wbIn      (wbIn),
		.wrapPulse (periodStart), // Counted as completed periods
		.wbOut     (wbOut),
		.control   (control)
	);

	phaseAccumulator phaseAccumulator_i (
		.CLK_32KHz (CLK_32KHz),
		.reset_n   (reset_n),
		.control   (control),
		.stepIndex (stepIndex),
		.wrapPulse (periodStart)
	);

	// Combinational lookup between the phase and output registers
	waveShaper waveShaper_i (
		.stepIndex    (stepIndex),
		.control      (control),
		.shapedSample (shapedSample)
	);

	amplitudeScaler amplitudeScaler_i (
		.CLK_32KHz    (CLK_32KHz),
		.reset_n      (reset_n),
		.shapedSample (shapedSample),
		.control      (control),
		.outputSample (outputSample)
	);

endmodule

`default_nettype wire

// ==== hw/amplitudeScaler.sv ====
// Output stage of the tone generator
// Registers the shaped sample scaled by the amplitude with rounding
`default_nettype none

module amplitudeScaler (
	input  logic                    CLK_32KHz,
	input  logic                    reset_n,
	input  logic [7:0]              shapedSample,
	input  signalGenPkg::genControl control,
	output logic [7:0]              outputSample
);

	logic [15:0] product; // Largest value 255*255 + 127 still fits
	logic [7:0]  scaled;

	assign product = 16'(shapedSample) * 16'(control.amplitude) + 16'd127;
	assign scaled = 8'(product / 16'd255); // Round to nearest

	always_ff @(posedge CLK_32KHz, negedge reset_n) begin
		if (!reset_n) begin
			outputSample <= 8'h00;
		end else if (!control.enable) begin
			outputSample <= 8'h00; // Quiet while stopped
		end else begin
			outputSample <= scaled;
		end
	end

	silentWhenDisabled: assert property (
		@(posedge CLK_32KHz) disable iff (!reset_n)
		!control.enable |=> (outputSample == 8'h00)
	) else $error("amplitudeScaler: output not silent after disable");

endmodule

`default_nettype wire

// ==== hw/waveShaper.sv ====
// Turns the step index into an 8-bit sample for the selected waveform
// Purely combinational, the amplitude scaler registers the result
`default_nettype none
`include "signalGen_cfg.svh"

module waveShaper (
	input  logic [6:0]              stepIndex,
	input  signalGenPkg::genControl control,
	output logic [7:0]              shapedSample
);

	localparam logic [6:0] halfStep = 7'(`STEP_COUNT / 2); // Index of the triangle peak

	logic [6:0] mirrorIndex; // Steps left until the period ends

	assign mirrorIndex = 7'(`STEP_COUNT - stepIndex);

	always_comb begin
		case (control.shape)
			signalGenPkg::SHAPE_TRIANGLE: begin
				if (stepIndex < halfStep) begin
					shapedSample = {stepIndex[5:0], 2'b00}; // Rising edge, 4 per step
				end else if (stepIndex == halfStep) begin
					shapedSample = 8'hFF; // Peak clipped to full scale
				end else begin
					shapedSample = {mirrorIndex[5:0], 2'b00};
				end
			end
			signalGenPkg::SHAPE_SQUARE: begin
				// High for the first half period
				if (stepIndex < halfStep) begin
					shapedSample = 8'hFF;
				end else begin
					shapedSample = 8'h00;
				end
			end
			signalGenPkg::SHAPE_SAWTOOTH: begin
				shapedSample = {stepIndex, 1'b0}; // Ramps to 254 then drops
			end
			default: begin
				shapedSample = 8'h00; // Silent
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/phaseAccumulator.sv ====
// Phase accumulator of the tone generator, adds the frequency word every tick
// Wraps modulo the phase modulus and flags each wrap with a one-cycle pulse
`default_nettype none
`include "signalGen_cfg.svh"

module phaseAccumulator (
	input  logic                    CLK_32KHz,
	input  logic                    reset_n,
	input  signalGenPkg::genControl control,
	output logic [6:0]              stepIndex,
	output logic                    wrapPulse
);

	logic [14:0] phase;    // Always below the modulus
	logic [15:0] phaseSum; // Room for the overshoot before the wrap
	logic        wraps;

	assign phaseSum = {1'b0, phase} + {2'b00, control.frequency};
	assign wraps = phaseSum >= 16'(`PHASE_MODULUS);

	always_ff @(posedge CLK_32KHz, negedge reset_n) begin
		if (!reset_n) begin
			phase <= '0;
			wrapPulse <= 1'b0;
		end else if (!control.enable) begin
			phase <= '0; // Parked at the start of a period
			wrapPulse <= 1'b0;
		end else if (wraps) begin
			// Keep the overshoot so the long-run frequency stays exact
			phase <= 15'(phaseSum - 16'(`PHASE_MODULUS));
			wrapPulse <= 1'b1;
		end else begin
			phase <= phaseSum[14:0];
			wrapPulse <= 1'b0;
		end
	end

	// 250 phase units per step, 128 steps per period
	assign stepIndex = 7'(phase / 15'(`PHASE_PER_STEP));

	// The index division relies on this bound to stay within the table
	phaseInRange: assert property (
		@(posedge CLK_32KHz) disable iff (!reset_n)
		phase < 15'(`PHASE_MODULUS)
	) else $error("phaseAccumulator: phase %0d out of range", phase);

endmodule

`default_nettype wire

// ==== hw/signalRegs.sv ====
// Wishbone classic slave holding the generator settings
// Also counts completed periods from the phase accumulator, saturating at all ones
`default_nettype none
`include "signalGen_cfg.svh"

module signalRegs (
	input  logic                    CLK_32KHz,
	input  logic                    reset_n,
	input  signalGenPkg::wbRequest  wbIn,
	input  logic                    wrapPulse,
	output signalGenPkg::wbResponse wbOut,
	output signalGenPkg::genControl control
);

	logic        ackReg;
	logic [15:0] readData;
	logic [15:0] periodCount;
	logic        accessStart; // First cycle of a transfer
	logic        writeStart;
	logic        clearPeriods;

	assign accessStart = wbIn.cyc && wbIn.stb && !ackReg;
	assign writeStart = accessStart && wbIn.we;

	// Turning the generator off restarts the period count
	assign clearPeriods = writeStart && (wbIn.adr == signalGenPkg::REG_CONTROL)
		&& !wbIn.dat[0];

	// Ack for one cycle, then drop even if stb stays high
	always_ff @(posedge CLK_32KHz, negedge reset_n) begin
		if (!reset_n) begin
			ackReg <= 1'b0;
		end else begin
			ackReg <= accessStart;
		end
	end

	always_ff @(posedge CLK_32KHz, negedge reset_n) begin
		if (!reset_n) begin
			control.enable <= 1'b0;
			control.shape <= signalGenPkg::SHAPE_TRIANGLE;
			control.frequency <= 14'(`RESET_FREQUENCY);
			control.amplitude <= 8'(`RESET_AMPLITUDE);
		end else if (writeStart) begin
			case (wbIn.adr)
				signalGenPkg::REG_FREQUENCY: begin
					control.frequency <= wbIn.dat[13:0];
				end
				signalGenPkg::REG_AMPLITUDE: begin
					control.amplitude <= wbIn.dat[7:0];
				end
				signalGenPkg::REG_CONTROL: begin
					control.enable <= wbIn.dat[0];
					control.shape <= signalGenPkg::waveShape'(wbIn.dat[2:1]);
				end
				default: begin
					// Period counter ignores writes, ack still given
				end
			endcase
		end
	end

	always_ff @(posedge CLK_32KHz, negedge reset_n) begin
		if (!reset_n) begin
			periodCount <= '0;
		end else if (clearPeriods) begin
			periodCount <= '0;
		end else if (wrapPulse && (periodCount != 16'hFFFF)) begin
			periodCount <= periodCount + 16'd1; // Sticks at the top
		end
	end

	// Read data captured on the ack edge
	always_ff @(posedge CLK_32KHz) begin
		if (accessStart) begin
			case (wbIn.adr)
				signalGenPkg::REG_FREQUENCY: readData <= {2'b00, control.frequency};
				signalGenPkg::REG_AMPLITUDE: readData <= {8'h00, control.amplitude};
				signalGenPkg::REG_CONTROL: begin
					readData <= {13'h0000, control.shape, control.enable};
				end
				default: readData <= periodCount;
			endcase
		end
	end

	assign wbOut.ack = ackReg;
	assign wbOut.dat = readData;

	// Single transfers only, so a second ack needs a fresh cycle in between
	ackNeverBackToBack: assert property (
		@(posedge CLK_32KHz) disable iff (!reset_n)
		wbOut.ack |=> !wbOut.ack
	) else $error("signalRegs: ack high on two consecutive cycles");

endmodule

`default_nettype wire

// ==== hw/signalGenPkg.sv ====
// Types shared by the register block and the datapath of the tone generator
// Bus requests and responses and the control word travel as packed structs
`default_nettype none
`include "signalGen_cfg.svh"

package signalGenPkg;

	typedef enum logic [1:0] {
		SHAPE_TRIANGLE,
		SHAPE_SQUARE,
		SHAPE_SAWTOOTH,
		SHAPE_SILENT
	} waveShape;

	typedef enum logic [1:0] {
		REG_FREQUENCY = `ADDR_FREQUENCY,
		REG_AMPLITUDE = `ADDR_AMPLITUDE,
		REG_CONTROL   = `ADDR_CONTROL,
		REG_PERIODS   = `ADDR_PERIODS // Read-only
	} regAddr;

	// Master to slave, held stable until ack
	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		regAddr      adr;
		logic [15:0] dat;
	} wbRequest;

	typedef struct packed {
		logic        ack;
		logic [15:0] dat; // Valid while ack is high
	} wbResponse;

	// Settings that steer the datapath
	typedef struct packed {
		logic        enable;
		waveShape    shape;
		logic [13:0] frequency; // Hz, one phase unit per tick
		logic [7:0]  amplitude;
	} genControl;

endpackage

`default_nettype wire

// ==== hw/signalGen_cfg.svh ====
// Fixed constants of the tone generator, shared by the package and the datapath
// Include wherever a phase, step or reset constant is needed
`ifndef SIGNALGEN_CFG_SVH
`define SIGNALGEN_CFG_SVH

// One period of phase equals one second of 32 kHz clock ticks
`define PHASE_MODULUS 32000

// 32000 / 250 gives 128 steps per period
`define PHASE_PER_STEP 250
`define STEP_COUNT 128

// Register map on the Wishbone side
`define ADDR_FREQUENCY 2'd0
`define ADDR_AMPLITUDE 2'd1
`define ADDR_CONTROL 2'd2
`define ADDR_PERIODS 2'd3

// Settings after reset
`define RESET_AMPLITUDE 255 // Full scale
`define RESET_FREQUENCY 1000 // Hz

`endif
